// ==== design/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // ########################################
    // Instruction formats

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // ########################################
    // Function codes

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] f7_sub = 7'b0100000;

endpackage

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } state_t;

    // ########################################
    // Mux selects

    typedef enum logic {
        addr_pc,
        addr_result
    } addr_src_t;

    typedef enum logic [1:0] {
        src_a_pc,
        src_a_old_pc,
        src_a_reg
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_reg,
        src_b_imm,
        src_b_four
    } src_b_t;

    typedef enum logic [1:0] {
        res_alu_reg,
        res_mdr,
        res_alu_live
    } result_src_t;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        addr_src_t   address_source;
        logic        ir_write;
        logic        pc_write;
        logic        reg_write;
        logic        mem_write;
        src_a_t      src_a;
        src_b_t      src_b;
        alu_op_t     alu_op;
        imm_sel_t    imm_sel;
        result_src_t result_src;
    } ctrl_word_t;

endpackage

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import ctrl_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_t     op,
    output logic [31:0] result,
    output logic        zero_flag,
    output logic        negative_flag
);

    logic less;

    assign less = $signed(a) < $signed(b); // Immune to subtraction overflow.

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {31'b0, less};
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    assign zero_flag     = (result == 32'd0);
    assign negative_flag = less;

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file import isa_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== design/mc_controller.sv ====
`timescale 1ns/1ps

module mc_controller import isa_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  instr_u     instr,
    input  logic       zero_flag,
    input  logic       negative_flag,
    output ctrl_word_t ctrl
);

    state_t     state;
    state_t     next_state;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       supported;
    logic       branch_taken;
    src_a_t     op_src_a;
    src_b_t     op_src_b;
    imm_sel_t   op_imm_sel;
    alu_op_t    op_alu;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
        case (f3)
            f3_add_sub: return sub ? alu_sub : alu_add;
            f3_slt:     return alu_slt;
            f3_xor:     return alu_xor;
            f3_or:      return alu_or;
            f3_and:     return alu_and;
            default:    return alu_add;
        endcase
    endfunction

    // ########################################
    // Decoder

    always_comb begin
        case (opcode)
            opc_op_imm, opc_op, opc_branch, opc_jal,
            opc_jalr, opc_lui, opc_load, opc_store: supported = 1'b1;
            default:                                supported = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  branch_taken = zero_flag;
            f3_bne:  branch_taken = !zero_flag;
            f3_blt:  branch_taken = negative_flag; // Signed compare from the ALU.
            f3_bge:  branch_taken = !negative_flag;
            default: branch_taken = 1'b0;
        endcase
    end

    // Operand setup held from execute through writeback, so the result register stays put.
    always_comb begin
        op_src_a   = src_a_reg;
        op_src_b   = src_b_imm;
        op_imm_sel = imm_i;
        op_alu     = alu_add;
        case (opcode)
            opc_op_imm: op_alu = arith_op(funct3, 1'b0);
            opc_op: begin
                op_src_b = src_b_reg;
                op_alu   = arith_op(funct3, instr.r.funct7 == f7_sub);
            end
            opc_branch: begin
                op_src_b = src_b_reg;
                op_alu   = alu_sub;
            end
            opc_lui: begin
                op_imm_sel = imm_u;
                op_alu     = alu_pass_b;
            end
            opc_store:         op_imm_sel = imm_s;
            opc_jal, opc_jalr: begin
                op_src_a = src_a_old_pc; // Link address is old PC plus four.
                op_src_b = src_b_four;
            end
            default:           op_alu = alu_add;
        endcase
    end

    // ########################################
    // State machine

    always_comb begin
        case (state)
            st_fetch:   next_state = st_decode;
            st_decode:  next_state = supported ? st_execute : st_fetch;
            st_execute: next_state = st_memory;
            st_memory:  next_state = st_writeback;
            default:    next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        ctrl.address_source = addr_pc;
        ctrl.ir_write       = 1'b0;
        ctrl.pc_write       = 1'b0;
        ctrl.reg_write      = 1'b0;
        ctrl.mem_write      = 1'b0;
        ctrl.src_a          = op_src_a;
        ctrl.src_b          = op_src_b;
        ctrl.alu_op         = op_alu;
        ctrl.imm_sel        = op_imm_sel;
        ctrl.result_src     = res_alu_reg;
        case (state)
            st_fetch: begin
                ctrl.ir_write   = 1'b1;
                ctrl.pc_write   = 1'b1; // PC advances by four.
                ctrl.src_a      = src_a_pc;
                ctrl.src_b      = src_b_four;
                ctrl.alu_op     = alu_add;
                ctrl.result_src = res_alu_live;
            end
            st_decode: begin
                ctrl.src_a   = src_a_old_pc; // Branch or jump target.
                ctrl.src_b   = src_b_imm;
                ctrl.alu_op  = alu_add;
                ctrl.imm_sel = (opcode == opc_jal) ? imm_j : imm_b;
            end
            st_execute: begin
                case (opcode)
                    opc_branch: ctrl.pc_write = branch_taken;
                    opc_jal:    ctrl.pc_write = 1'b1;
                    opc_jalr: begin
                        ctrl.pc_write   = 1'b1;
                        ctrl.src_a      = src_a_reg;
                        ctrl.src_b      = src_b_imm;
                        ctrl.imm_sel    = imm_i;
                        ctrl.alu_op     = alu_add;
                        ctrl.result_src = res_alu_live;
                    end
                    default:    ctrl.pc_write = 1'b0;
                endcase
            end
            st_memory: begin
                if (opcode == opc_load || opcode == opc_store) begin
                    ctrl.address_source = addr_result;
                end
                ctrl.mem_write = (opcode == opc_store);
            end
            st_writeback: begin
                ctrl.reg_write  = !(opcode == opc_branch || opcode == opc_store);
                ctrl.result_src = (opcode == opc_load) ? res_mdr : res_alu_reg;
            end
            default: ctrl.ir_write = 1'b0;
        endcase
    end

endmodule

// ==== design/mc_datapath.sv ====
`timescale 1ns/1ps

module mc_datapath import isa_pkg::*, ctrl_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  ctrl_word_t      ctrl,
    input  logic [xlen-1:0] mem_rdata,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] rf_rdata1,
    input  logic [xlen-1:0] rf_rdata2,
    output instr_u          instr,
    output logic [xlen-1:0] alu_a,
    output logic [xlen-1:0] alu_b,
    output alu_op_t         alu_op,
    output logic [4:0]      rf_raddr1,
    output logic [4:0]      rf_raddr2,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic            rf_we,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_we
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] old_pc;
    logic [xlen-1:0] mdr;
    logic [xlen-1:0] reg_a;
    logic [xlen-1:0] reg_b;
    logic [xlen-1:0] alu_reg;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] result;
    instr_u          ir;

    // ########################################
    // Architectural registers

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ctrl.pc_write) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir     <= mem_rdata;
            old_pc <= pc; // Base for targets and the link address.
        end
        mdr     <= mem_rdata;
        reg_a   <= rf_rdata1;
        reg_b   <= rf_rdata2;
        alu_reg <= alu_result;
    end

    // ########################################
    // Immediates and multiplexers

    always_comb begin
        case (ctrl.imm_sel)
            imm_i:   imm_ext = {{20{ir.i.imm[11]}}, ir.i.imm};
            imm_s:   imm_ext = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            imm_b:   imm_ext = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                                ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            imm_u:   imm_ext = {ir.u.imm, 12'b0};
            imm_j:   imm_ext = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
                                ir.j.imm_11, ir.j.imm_10_1, 1'b0};
            default: imm_ext = '0;
        endcase
    end

    always_comb begin
        case (ctrl.src_a)
            src_a_pc:     alu_a = pc;
            src_a_old_pc: alu_a = old_pc;
            default:      alu_a = reg_a;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            src_b_reg: alu_b = reg_b;
            src_b_imm: alu_b = imm_ext;
            default:   alu_b = 32'd4;
        endcase
    end

    always_comb begin
        case (ctrl.result_src)
            res_mdr:      result = mdr;
            res_alu_live: result = alu_result;
            default:      result = alu_reg;
        endcase
    end

    assign instr     = ir;
    assign alu_op    = ctrl.alu_op;
    assign rf_raddr1 = ir.r.rs1;
    assign rf_raddr2 = ir.r.rs2;
    assign rf_waddr  = ir.r.rd;
    assign rf_wdata  = result;
    assign rf_we     = ctrl.reg_write;
    assign mem_addr  = (ctrl.address_source == addr_result) ? alu_reg : pc;
    assign mem_wdata = reg_b; // Store data read in decode.
    assign mem_we    = ctrl.mem_write;

endmodule

// ==== design/riscv_multicycle_core.sv ====
`timescale 1ns/1ps

module riscv_multicycle_core import isa_pkg::*, ctrl_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_we,
    input  logic [xlen-1:0] mem_rdata
);

    ctrl_word_t      ctrl;
    instr_u          instr;
    logic            zero_flag;
    logic            negative_flag;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    alu_op_t         alu_op;
    logic [4:0]      rf_raddr1;
    logic [4:0]      rf_raddr2;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] rf_rdata2;
    logic [xlen-1:0] rf_wdata;
    logic            rf_we;

    mc_controller u_controller (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .zero_flag     (zero_flag),
        .negative_flag (negative_flag),
        .ctrl          (ctrl)
    );

    mc_datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .instr      (instr),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .rf_we      (rf_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we)
    );

    // Flags go straight to the controller for the branch decision in execute.
    alu_unit u_alu (
        .a             (alu_a),
        .b             (alu_b),
        .op            (alu_op),
        .result        (alu_result),
        .zero_flag     (zero_flag),
        .negative_flag (negative_flag)
    );

    register_file u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// ==== testbench/tb_iss.svh ====
// ########################################
// Instruction-set model of the supported RV32I subset

logic [xlen-1:0] model_mem [0:511];
logic [xlen-1:0] model_regs [0:31];
logic [xlen-1:0] model_pc;

function automatic logic [xlen-1:0] i_imm(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [xlen-1:0] s_imm(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic logic [xlen-1:0] b_imm(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [xlen-1:0] j_imm(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

task automatic reset_model(input logic [xlen-1:0] start_pc);
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_pc = start_pc;
endtask

// Executes the instruction at model_pc and reports its length in cycles.
task automatic step_model(output int cycles, output logic store,
                          output logic [xlen-1:0] st_addr, output logic [xlen-1:0] st_data);
    logic [31:0]     w;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [xlen-1:0] v1;
    logic [xlen-1:0] v2;
    logic [xlen-1:0] res;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] ea;
    logic            wr;
    logic            taken;
    w       = model_mem[model_pc[10:2]];
    opc     = w[6:0];
    rd      = w[11:7];
    f3      = w[14:12];
    v1      = model_regs[w[19:15]];
    v2      = model_regs[w[24:20]];
    next_pc = model_pc + 4;
    res     = '0;
    wr      = 1'b0;
    store   = 1'b0;
    st_addr = '0;
    st_data = '0;
    cycles  = 5;
    case (opc)
        opc_op_imm: begin
            wr = 1'b1;
            case (f3)
                f3_xor:  res = v1 ^ i_imm(w);
                f3_or:   res = v1 | i_imm(w);
                f3_and:  res = v1 & i_imm(w);
                default: res = v1 + i_imm(w);
            endcase
        end
        opc_op: begin
            wr = 1'b1;
            case (f3)
                f3_add_sub: res = w[30] ? v1 - v2 : v1 + v2;
                f3_slt:     res = {31'b0, $signed(v1) < $signed(v2)};
                f3_xor:     res = v1 ^ v2;
                f3_or:      res = v1 | v2;
                default:    res = v1 & v2;
            endcase
        end
        opc_branch: begin
            case (f3)
                f3_beq:  taken = (v1 == v2);
                f3_bne:  taken = (v1 != v2);
                f3_blt:  taken = ($signed(v1) < $signed(v2));
                f3_bge:  taken = ($signed(v1) >= $signed(v2));
                default: taken = 1'b0;
            endcase
            if (taken) begin
                next_pc = model_pc + b_imm(w);
            end
        end
        opc_jal: begin
            wr      = 1'b1;
            res     = model_pc + 4;
            next_pc = model_pc + j_imm(w);
        end
        opc_jalr: begin
            wr      = 1'b1;
            res     = model_pc + 4;
            next_pc = (v1 + i_imm(w)) & ~32'd1;
        end
        opc_lui: begin
            wr  = 1'b1;
            res = {w[31:12], 12'b0};
        end
        opc_load: begin
            wr  = 1'b1;
            ea  = v1 + i_imm(w);
            res = model_mem[ea[10:2]];
        end
        opc_store: begin
            store   = 1'b1;
            st_addr = v1 + s_imm(w);
            st_data = v2;
            model_mem[st_addr[10:2]] = v2;
        end
        default: cycles = 2; // Unknown opcodes leave decode straight for fetch.
    endcase
    if (wr && rd != 5'd0) begin
        model_regs[rd] = res;
    end
    model_pc = next_pc;
endtask

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import isa_pkg::*; ();

    localparam logic [xlen-1:0] reset_pc = 32'h0;
    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int num_instr    = 400;
    localparam int dump_count   = 32;
    localparam logic [11:0] dump_base = 12'h700;
    localparam int watchdog_cycles = reset_cycles + (num_instr + dump_count) * 5 + 20;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic            mem_we;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] mem [0:511];
    logic            wr_we;
    logic [xlen-1:0] wr_addr;
    logic [xlen-1:0] wr_data;
    integer          seed = 18;

    `include "tb_iss.svh"

    riscv_multicycle_core #(
        .reset_pc (reset_pc)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    assign mem_rdata = mem[mem_addr[10:2]]; // Combinational read.

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Store captured mid-cycle, written just after the edge.
    always begin
        @(negedge clk);
        wr_we   = mem_we;
        wr_addr = mem_addr;
        wr_data = mem_wdata;
        @(posedge clk);
        #1;
        if (wr_we) begin
            mem[wr_addr[10:2]] = wr_data;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog timeout: the core stopped making progress");
        $display("Testbench failed");
        $fatal(1);
    end

    // ########################################
    // Compare tasks

    task automatic check_addr(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // ########################################
    // Program generation

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic make_instr(input int w, output logic [xlen-1:0] word);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [11:0] lsoff;
        logic [2:0]  f3i;
        logic [2:0]  f3r;
        logic [2:0]  f3b;
        logic [6:0]  f7;
        logic [12:0] boff;
        logic [20:0] joff;
        int          span;
        int          tw;
        span  = 1 + pick(8);
        if (w + span > 255) begin
            span = 255 - w; // Forward targets stay inside the code words.
        end
        rd    = 5'(pick(32));
        rs1   = 5'(pick(32));
        rs2   = 5'(pick(32));
        imm   = 12'($random(seed));
        upper = 20'($random(seed));
        lsoff = 12'(12'h400 + 4 * pick(256));
        boff  = 13'(4 * span);
        joff  = 21'(4 * span);
        case (pick(4))
            0:       f3i = f3_add_sub;
            1:       f3i = f3_xor;
            2:       f3i = f3_or;
            default: f3i = f3_and;
        endcase
        f3r = (pick(5) == 4) ? f3_slt : f3i;
        f7  = (f3r == f3_add_sub && pick(2) == 1) ? f7_sub : 7'b0;
        case (pick(4))
            0:       f3b = f3_beq;
            1:       f3b = f3_bne;
            2:       f3b = f3_blt;
            default: f3b = f3_bge;
        endcase
        tw = pick(255);
        if (tw == w) begin
            tw = w + 1;
        end
        case (pick(16))
            0: begin
                word = $random(seed);
                case (pick(4))
                    0:       word[6:0] = 7'b0010111;
                    1:       word[6:0] = 7'b0001111;
                    2:       word[6:0] = 7'b1110011;
                    default: word[6:0] = 7'b1111111;
                endcase
            end
            1, 2, 3:   word = {imm, rs1, f3i, rd, opc_op_imm};
            4, 5, 6:   word = {f7, rs2, rs1, f3r, rd, opc_op};
            7:         word = {upper, rd, opc_lui};
            8, 9:      word = {lsoff, 5'd0, 3'b010, rd, opc_load};
            10, 11:    word = {lsoff[11:5], rs2, 5'd0, 3'b010, lsoff[4:0], opc_store};
            12, 13:    word = {boff[12], boff[10:5], rs2, rs1, f3b, boff[4:1], boff[11],
                               opc_branch};
            14:        word = {joff[20], joff[10:1], joff[11], joff[19:12], rd, opc_jal};
            default:   word = {12'(4 * tw), 5'd0, 3'b000, rd, opc_jalr};
        endcase
    endtask

    task automatic build_program();
        logic [20:0] back;
        back = 21'(-1020);
        for (int w = 0; w < 255; w++) begin
            make_instr(w, mem[w]);
        end
        mem[255] = {back[20], back[10:1], back[11], back[19:12], 5'd0, opc_jal}; // Wrap to 0.
        for (int w = 256; w < 512; w++) begin
            mem[w] = $random(seed);
        end
        for (int w = 0; w < 512; w++) begin
            model_mem[w] = mem[w];
        end
    endtask

    // One SW per register, starting at the next fetch address.
    task automatic place_dump();
        logic [11:0] off;
        logic [8:0]  idx;
        for (int i = 0; i < dump_count; i++) begin
            off            = dump_base + 12'(4 * i);
            idx            = model_pc[10:2] + 9'(i);
            mem[idx]       = {off[11:5], 5'(i), 5'd0, 3'b010, off[4:0], opc_store};
            model_mem[idx] = mem[idx];
        end
    endtask

    // ########################################
    // Run control

    task automatic run_instructions(input int count, input string phase);
        int              cycles;
        logic            store;
        logic [xlen-1:0] st_addr;
        logic [xlen-1:0] st_data;
        logic [xlen-1:0] fetch_pc;
        for (int n = 0; n < count; n++) begin
            fetch_pc = model_pc;
            step_model(cycles, store, st_addr, st_data);
            for (int c = 1; c <= cycles; c++) begin
                @(negedge clk);
                if (c == 1) begin
                    check_addr($sformatf("%s fetch %0d", phase, n), fetch_pc, mem_addr);
                end
                check_strobe($sformatf("%s strobe %0d cycle %0d", phase, n, c),
                             store && c == 4, mem_we);
                if (store && c == 4) begin
                    check_addr($sformatf("%s store address %0d", phase, n), st_addr, mem_addr);
                    check_word($sformatf("%s store data %0d", phase, n), st_data, mem_wdata);
                end
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        build_program();
        reset_model(reset_pc);
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            check_strobe($sformatf("reset strobe %0d", i), 1'b0, mem_we);
            check_addr($sformatf("reset address %0d", i), reset_pc, mem_addr);
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        run_instructions(num_instr, "program");
        place_dump();
        run_instructions(dump_count, "register dump");
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+testbench
design/isa_pkg.sv
design/ctrl_pkg.sv
design/alu_unit.sv
design/register_file.sv
design/mc_controller.sv
design/mc_datapath.sv
design/riscv_multicycle_core.sv
testbench/tb_core.sv
